// File: list.f
logic/csr_pkg.sv
logic/trap_pkg.sv
logic/csr_write_arbiter.sv
logic/csr_field_reg.sv
logic/mstatus_reg.sv
logic/trap_unit.sv
logic/csr_file.sv
logic/csr_subsystem.sv
testbench/tb_clock.sv
testbench/csr_tb.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module csr_tb -f list.f --Mdir obj_dir -o csr_sim

output=$(./obj_dir/csr_sim)
echo "$output"

if echo "$output" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1

// File: testbench/csr_tb.sv
`timescale 1ns/1ps

module csr_tb;
    import csr_pkg::*;
    import trap_pkg::*;

    localparam int clock_period = 100;
    // Reset, two full sweeps, unknown reads, writes, traps and mret returns
    localparam int test_cycles = 10 + 2 * 14 + 20 + 200 + 50 + 20 * 9 + 10 * 3;
    localparam int margin_cycles = 200;

    logic clk;
    logic reset;
    csr_write_t instr_write;
    csr_addr_t csr_addr;
    csr_word_t csr_out;
    logic is_mret;
    logic trap_valid;
    trap_event_t trap_event;
    logic meip;
    logic mtip;
    logic msip;
    logic stall;
    logic trap_busy;

    logic [31:0] rng_state;
    int value_errors;
    int other_errors;
    logic busy_seen;
    csr_addr_t known_addrs [0:13];

    // Reference model of the register state
    logic m_mie_bit;
    logic m_mpie_bit;
    csr_word_t m_mie;
    csr_word_t m_mscratch;
    csr_word_t m_mepc;
    mcause_t m_mcause;
    csr_word_t m_mtval;
    int m_busy;
    trap_event_t m_event;

    tb_clock clock_gen (
        .clk(clk)
    );

    csr_subsystem DUT (.*);

    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Mostly implemented registers and now and then any address
    function csr_addr_t pick_addr();
        logic [31:0] r;
        r = next_random();
        if (r[7:4] < 4'd14)
            return known_addrs[r[7:4]];
        return r[19:8];
    endfunction

    function csr_word_t model_read(csr_addr_t a);
        csr_word_t status;
        csr_word_t pending;
        status = 32'h0000_1800;
        status[3] = m_mie_bit;
        status[7] = m_mpie_bit;
        pending = '0;
        pending[11] = meip;
        pending[7] = mtip;
        pending[3] = msip;
        if (is_mret)
            return m_mepc;
        case (a)
            mstatus_addr: return status;
            misa_addr: return 32'h4000_0100;
            mtvec_addr: return mtvec_value;
            mie_addr: return m_mie;
            mscratch_addr: return m_mscratch;
            mepc_addr: return m_mepc;
            mcause_addr: return csr_word_t'(m_mcause);
            mtval_addr: return m_mtval;
            mip_addr: return pending;
            default: return '0;
        endcase
    endfunction

    task automatic check_word(string what, csr_word_t got, csr_word_t expected);
        if (got !== expected)
        begin
            $display("Error at %0d ns: %s read %h, expected %h", $time, what, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_mcause(string what, mcause_t got, mcause_t expected);
        if (got !== expected)
        begin
            $display("Error at %0d ns: %s read interrupt %b code %0d, expected %b code %0d",
                $time, what, got.interrupt, got.code, expected.interrupt, expected.code);
            value_errors++;
        end
    endtask

    task automatic check_flag(string what, logic got, logic expected);
        if (got !== expected)
        begin
            $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, expected);
            value_errors++;
        end
    endtask

    // One rising edge of the reference model
    task automatic model_edge();
        logic was_busy;
        was_busy = (m_busy != 0);
        if (was_busy)
        begin
            case (m_busy)
                3:
                begin
                    m_mepc = m_event.pc & 32'hffff_fffc;
                    m_mpie_bit = m_mie_bit;
                    m_mie_bit = 1'b0;
                end
                2: m_mcause = m_event.cause;
                default: m_mtval = m_event.tval;
            endcase
            m_busy--;
        end
        else if (instr_write.valid)
        begin
            case (instr_write.addr)
                mstatus_addr:
                begin
                    m_mie_bit = instr_write.data[3];
                    m_mpie_bit = instr_write.data[7];
                end
                mie_addr: m_mie = instr_write.data & 32'h0000_0888;
                mscratch_addr: m_mscratch = instr_write.data;
                mepc_addr: m_mepc = instr_write.data & 32'hffff_fffc;
                mcause_addr: m_mcause = mcause_t'(instr_write.data);
                mtval_addr: m_mtval = instr_write.data;
                default: ;
            endcase
        end
        if (is_mret)
        begin
            m_mie_bit = m_mpie_bit;
            m_mpie_bit = 1'b1;
        end
        if (trap_valid && !was_busy)
        begin
            m_event = trap_event;
            m_busy = 3;
        end
    endtask

    // Check mid cycle, step the model, then drop strobes after the edge
    task automatic run_cycle();
        logic model_stall;
        #50;
        model_stall = instr_write.valid && (m_busy != 0);
        if (csr_addr == mcause_addr && !is_mret)
            check_mcause("mcause", mcause_t'(csr_out), mcause_t'(model_read(csr_addr)));
        else
            check_word($sformatf("csr %h", csr_addr), csr_out, model_read(csr_addr));
        check_flag("stall", stall, model_stall);
        check_flag("trap_busy", trap_busy, m_busy != 0);
        busy_seen = trap_busy;
        model_edge();
        @(posedge clk);
        #10;
        is_mret = 1'b0;
        trap_valid = 1'b0;
        // A stalled write stays on the port
        if (!model_stall)
            instr_write.valid = 1'b0;
    endtask

    task automatic read_all_known();
        for (int i = 0; i < 14; i++)
        begin
            csr_addr = known_addrs[i];
            run_cycle();
        end
    endtask

    task automatic random_writes(int count);
        logic [31:0] r;
        repeat (count)
        begin
            r = next_random();
            instr_write.valid = r[0];
            instr_write.addr = pick_addr();
            instr_write.data = next_random();
            meip = r[1];
            mtip = r[2];
            msip = r[3];
            csr_addr = pick_addr();
            run_cycle();
        end
    endtask

    task automatic trap_entry();
        int busy_cycles;
        logic [31:0] r;
        trap_event.pc = next_random() & 32'hffff_fffc;
        trap_event.tval = next_random();
        trap_event.cause.interrupt = 1'b0;
        r = next_random();
        case (r[1:0])
            2'd0: trap_event.cause.code = cause_illegal_instr;
            2'd1: trap_event.cause.code = cause_breakpoint;
            2'd2: trap_event.cause.code = cause_load_misaligned;
            default: trap_event.cause.code = cause_ecall_m;
        endcase
        trap_valid = 1'b1;
        csr_addr = mstatus_addr;
        run_cycle();
        // Instruction write that collides with trap entry
        instr_write.valid = 1'b1;
        instr_write.addr = pick_addr();
        instr_write.data = next_random();
        busy_cycles = 0;
        do
        begin
            csr_addr = pick_addr();
            run_cycle();
            if (busy_seen)
                busy_cycles++;
        end
        while (busy_seen && busy_cycles < 10);
        if (busy_cycles != 3)
        begin
            $display("trap_busy was high for %0d cycles instead of 3", busy_cycles);
            other_errors++;
        end
        csr_addr = mepc_addr;
        run_cycle();
        csr_addr = mcause_addr;
        run_cycle();
        csr_addr = mtval_addr;
        run_cycle();
        csr_addr = mstatus_addr;
        run_cycle();
    endtask

    task automatic mret_return();
        instr_write.valid = 1'b1;
        instr_write.addr = mstatus_addr;
        instr_write.data = next_random();
        csr_addr = mstatus_addr;
        run_cycle();
        is_mret = 1'b1;
        csr_addr = pick_addr();
        run_cycle();
        csr_addr = mstatus_addr;
        run_cycle();
    endtask

    initial
    begin
        rng_state = 32'hf9cc;
        value_errors = 0;
        other_errors = 0;
        busy_seen = 1'b0;
        known_addrs = '{mvendorid_addr, marchid_addr, mimpid_addr, mhartid_addr,
            mstatus_addr, misa_addr, mie_addr, mtvec_addr, mcounteren_addr,
            mscratch_addr, mepc_addr, mcause_addr, mtval_addr, mip_addr};
        reset = 1'b1;
        instr_write = '0;
        csr_addr = '0;
        is_mret = 1'b0;
        trap_valid = 1'b0;
        trap_event = '0;
        meip = 1'b0;
        mtip = 1'b0;
        msip = 1'b0;
        m_mie_bit = 1'b0;
        m_mpie_bit = 1'b0;
        m_mie = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_mtval = '0;
        m_busy = 0;
        m_event = '0;
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;

        read_all_known();
        repeat (20)
        begin
            csr_addr = 12'(next_random());
            run_cycle();
        end
        random_writes(200);
        repeat (20) trap_entry();
        repeat (10) mret_return();
        random_writes(50);
        read_all_known();

        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog
    initial
    begin
        #((test_cycles + margin_cycles) * clock_period);
        $display("Timeout: tests did not finish within %0d cycles", test_cycles + margin_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 100 ns period
    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

// File: logic/csr_subsystem.sv
`timescale 1ns/1ps

module csr_subsystem (
    input logic clk,
    input logic reset,
    input csr_pkg::csr_write_t instr_write,
    input csr_pkg::csr_addr_t csr_addr,
    output csr_pkg::csr_word_t csr_out,
    input logic is_mret,
    input logic trap_valid,
    input trap_pkg::trap_event_t trap_event,
    input logic meip,
    input logic mtip,
    input logic msip,
    output logic stall,
    output logic trap_busy
);
    import csr_pkg::*;

    csr_write_t trap_write;
    csr_write_t port_write;
    logic mstatus_trap;

    csr_write_arbiter arbiter_inst (
        .clk(clk),
        .reset(reset),
        .instr_write(instr_write),
        .trap_write(trap_write),
        .trap_busy(trap_busy),
        .port_write(port_write),
        .stall(stall)
    );

    trap_unit trap_inst (
        .clk(clk),
        .reset(reset),
        .trap_valid(trap_valid),
        .trap_event(trap_event),
        .trap_write(trap_write),
        .mstatus_trap(mstatus_trap),
        .trap_busy(trap_busy)
    );

    csr_file csr_file_inst (
        .clk(clk),
        .reset(reset),
        .port_write(port_write),
        .mstatus_trap(mstatus_trap),
        .is_mret(is_mret),
        .csr_addr(csr_addr),
        .meip(meip),
        .mtip(mtip),
        .msip(msip),
        .csr_out(csr_out)
    );

endmodule

// File: logic/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input logic clk,
    input logic reset,
    input csr_pkg::csr_write_t port_write,
    input logic mstatus_trap,
    input logic is_mret,
    input csr_pkg::csr_addr_t csr_addr,
    input logic meip,
    input logic mtip,
    input logic msip,
    output csr_pkg::csr_word_t csr_out
);
    import csr_pkg::*;
    import trap_pkg::*;

    logic write_mstatus;
    logic write_mie;
    logic write_mscratch;
    logic write_mepc;
    logic write_mcause;
    logic write_mtval;

    csr_word_t mstatus;
    csr_word_t mie;
    csr_word_t mip;
    csr_word_t mscratch;
    csr_word_t mepc;
    csr_word_t mtval;
    mcause_t mcause;
    csr_word_t read_value;

    // Write decode ignores read-only and unknown addresses
    assign write_mstatus = port_write.valid && (port_write.addr == mstatus_addr);
    assign write_mie = port_write.valid && (port_write.addr == mie_addr);
    assign write_mscratch = port_write.valid && (port_write.addr == mscratch_addr);
    assign write_mepc = port_write.valid && (port_write.addr == mepc_addr);
    assign write_mcause = port_write.valid && (port_write.addr == mcause_addr);
    assign write_mtval = port_write.valid && (port_write.addr == mtval_addr);

    mstatus_reg mstatus_inst (
        .clk(clk),
        .reset(reset),
        .write_enable(write_mstatus),
        .write_data(port_write.data),
        .trap_entry(mstatus_trap),
        .is_mret(is_mret),
        .mstatus(mstatus)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mie <= '0;
        end
        else if (write_mie)
        begin
            mie <= port_write.data & mie_write_mask;
        end
    end

    // Pending bits follow the interrupt lines directly
    always_comb
    begin
        mip = '0;
        mip[irq_ext_bit] = meip;
        mip[irq_timer_bit] = mtip;
        mip[irq_soft_bit] = msip;
    end

    csr_field_reg #(.data_t(csr_word_t), .reset_value('0)) mscratch_inst (
        .clk(clk),
        .reset(reset),
        .write_enable(write_mscratch),
        .write_data(port_write.data),
        .value(mscratch)
    );

    // IALIGN is 32 so the low two bits of mepc stay zero
    csr_field_reg #(.data_t(csr_word_t), .reset_value('0)) mepc_inst (
        .clk(clk),
        .reset(reset),
        .write_enable(write_mepc),
        .write_data(port_write.data & mepc_write_mask),
        .value(mepc)
    );

    csr_field_reg #(.data_t(mcause_t), .reset_value('0)) mcause_inst (
        .clk(clk),
        .reset(reset),
        .write_enable(write_mcause),
        .write_data(mcause_t'(port_write.data)),
        .value(mcause)
    );

    csr_field_reg #(.data_t(csr_word_t), .reset_value('0)) mtval_inst (
        .clk(clk),
        .reset(reset),
        .write_enable(write_mtval),
        .write_data(port_write.data),
        .value(mtval)
    );

    always_comb
    begin
        case (csr_addr)
            mvendorid_addr: read_value = mvendorid_value;
            marchid_addr: read_value = marchid_value;
            mimpid_addr: read_value = mimpid_value;
            mhartid_addr: read_value = mhartid_value;
            mstatus_addr: read_value = mstatus;
            misa_addr: read_value = misa_value;
            mie_addr: read_value = mie;
            mtvec_addr: read_value = mtvec_value;
            mcounteren_addr: read_value = mcounteren_value;
            mscratch_addr: read_value = mscratch;
            mepc_addr: read_value = mepc;
            mcause_addr: read_value = csr_word_t'(mcause);
            mtval_addr: read_value = mtval;
            mip_addr: read_value = mip;
            default: read_value = '0;
        endcase
    end

    // The mret encoding decodes to a CSR address that does not exist here
    assign csr_out = is_mret ? mepc : read_value;

endmodule

// File: logic/trap_unit.sv
`timescale 1ns/1ps

module trap_unit (
    input logic clk,
    input logic reset,
    input logic trap_valid,
    input trap_pkg::trap_event_t trap_event,
    output csr_pkg::csr_write_t trap_write,
    output logic mstatus_trap,
    output logic trap_busy
);
    import csr_pkg::*;
    import trap_pkg::*;

    typedef enum logic [1:0] {
        state_idle,
        state_write_epc,
        state_write_cause,
        state_write_tval
    } trap_state_t;

    trap_state_t state;
    trap_event_t held_event;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= state_idle;
        end
        else
        begin
            case (state)
                state_idle:
                begin
                    if (trap_valid)
                    begin
                        state <= state_write_epc;
                    end
                end
                state_write_epc: state <= state_write_cause;
                state_write_cause: state <= state_write_tval;
                default: state <= state_idle;
            endcase
        end
    end

    // Event payload captured as the trap is accepted
    always_ff @(posedge clk)
    begin
        if (state == state_idle && trap_valid)
        begin
            held_event <= trap_event;
        end
    end

    // One CSR write per busy cycle
    always_comb
    begin
        trap_write = '0;
        case (state)
            state_write_epc:
            begin
                trap_write.valid = 1'b1;
                trap_write.addr = mepc_addr;
                trap_write.data = held_event.pc;
            end
            state_write_cause:
            begin
                trap_write.valid = 1'b1;
                trap_write.addr = mcause_addr;
                trap_write.data = csr_word_t'(held_event.cause);
            end
            state_write_tval:
            begin
                trap_write.valid = 1'b1;
                trap_write.addr = mtval_addr;
                trap_write.data = held_event.tval;
            end
            default: trap_write = '0;
        endcase
    end

    assign mstatus_trap = (state == state_write_epc);
    assign trap_busy = (state != state_idle);

    // The core must not raise a new trap during entry
    assert property (@(posedge clk) disable iff (reset)
        trap_busy |-> !trap_valid)
        else $error("trap_unit: trap_valid while trap entry is busy");

endmodule

// File: logic/mstatus_reg.sv
`timescale 1ns/1ps

module mstatus_reg (
    input logic clk,
    input logic reset,
    input logic write_enable,
    input csr_pkg::csr_word_t write_data,
    input logic trap_entry,
    input logic is_mret,
    output csr_pkg::csr_word_t mstatus
);
    import csr_pkg::*;

    logic status_mie;
    logic status_mpie;

    // Trap entry first, then mret, then a plain CSR write
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            status_mie <= 1'b0;
            status_mpie <= 1'b0;
        end
        else if (trap_entry)
        begin
            status_mpie <= status_mie;
            status_mie <= 1'b0;
        end
        else if (is_mret)
        begin
            status_mie <= status_mpie;
            status_mpie <= 1'b1;
        end
        else if (write_enable)
        begin
            status_mie <= write_data[mstatus_mie_bit];
            status_mpie <= write_data[mstatus_mpie_bit];
        end
    end

    // Machine mode only, so MPP is hardwired
    always_comb
    begin
        mstatus = '0;
        mstatus[mstatus_mie_bit] = status_mie;
        mstatus[mstatus_mpie_bit] = status_mpie;
        mstatus[mstatus_mpp_hi:mstatus_mpp_lo] = machine_mode;
    end

    assert property (@(posedge clk) disable iff (reset)
        !(trap_entry && is_mret))
        else $error("mstatus_reg: trap entry and mret in the same cycle");

endmodule

// File: logic/csr_field_reg.sv
`timescale 1ns/1ps

module csr_field_reg #(
    parameter type data_t = logic [31:0],
    parameter data_t reset_value = '0
) (
    input logic clk,
    input logic reset,
    input logic write_enable,
    input data_t write_data,
    output data_t value
);

    data_t stored;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stored <= reset_value;
        end
        else if (write_enable)
        begin
            stored <= write_data;
        end
    end

    assign value = stored;

endmodule

// File: logic/csr_write_arbiter.sv
`timescale 1ns/1ps

module csr_write_arbiter (
    input logic clk,
    input logic reset,
    input csr_pkg::csr_write_t instr_write,
    input csr_pkg::csr_write_t trap_write,
    input logic trap_busy,
    output csr_pkg::csr_write_t port_write,
    output logic stall
);
    import csr_pkg::*;

    logic grant_trap;
    logic grant_instr;

    // Fixed priority where the trap unit always wins
    always_comb
    begin
        grant_trap = trap_write.valid;
        grant_instr = instr_write.valid && !trap_write.valid && !trap_busy;
        stall = instr_write.valid && !grant_instr;

        if (grant_trap)
        begin
            port_write = trap_write;
        end
        else
        begin
            port_write = instr_write;
            port_write.valid = grant_instr;
        end
    end

    // Trap writes come only during trap entry, so the busy stall
    // keeps the instruction side off the port for all of them
    assert property (@(posedge clk) disable iff (reset)
        trap_write.valid |-> trap_busy)
        else $error("csr_write_arbiter: trap write outside trap entry");

    // Pipeline must keep a stalled write on its port until it is taken
    assert property (@(posedge clk) disable iff (reset)
        stall |=> instr_write.valid)
        else $error("csr_write_arbiter: stalled write dropped by pipeline");

endmodule

// File: logic/trap_pkg.sv
package trap_pkg;

    typedef logic [30:0] cause_code_t;

    // Synchronous exception codes
    localparam cause_code_t cause_illegal_instr = 31'd2;
    localparam cause_code_t cause_breakpoint = 31'd3;
    localparam cause_code_t cause_load_misaligned = 31'd4;
    localparam cause_code_t cause_ecall_m = 31'd11;

    // Same layout as the mcause register
    typedef struct packed {
        logic interrupt;
        cause_code_t code;
    } mcause_t;

    typedef struct packed {
        csr_pkg::csr_word_t pc;
        mcause_t cause;
        csr_pkg::csr_word_t tval;
    } trap_event_t;

endpackage

// File: logic/csr_pkg.sv
package csr_pkg;

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_word_t;

    // Machine information, read-only
    localparam csr_addr_t mvendorid_addr = 12'hf11;
    localparam csr_addr_t marchid_addr = 12'hf12;
    localparam csr_addr_t mimpid_addr = 12'hf13;
    localparam csr_addr_t mhartid_addr = 12'hf14;

    // Trap setup
    localparam csr_addr_t mstatus_addr = 12'h300;
    localparam csr_addr_t misa_addr = 12'h301;
    localparam csr_addr_t mie_addr = 12'h304;
    localparam csr_addr_t mtvec_addr = 12'h305;
    localparam csr_addr_t mcounteren_addr = 12'h306;

    // Trap handling
    localparam csr_addr_t mscratch_addr = 12'h340;
    localparam csr_addr_t mepc_addr = 12'h341;
    localparam csr_addr_t mcause_addr = 12'h342;
    localparam csr_addr_t mtval_addr = 12'h343;
    localparam csr_addr_t mip_addr = 12'h344;

    localparam csr_word_t mvendorid_value = 32'h0000_0000;
    localparam csr_word_t marchid_value = 32'h0000_0000;
    localparam csr_word_t mimpid_value = 32'h0000_0000;
    localparam csr_word_t mhartid_value = 32'h0000_0000;
    // MXL = 32 bit, I extension only
    localparam csr_word_t misa_value = 32'h4000_0100;
    // Handler base, mode bits 1:0 = direct
    localparam csr_word_t mtvec_value = 32'h0000_0100;
    localparam csr_word_t mcounteren_value = 32'h0000_0000;

    // MSIE, MTIE and MEIE only
    localparam csr_word_t mie_write_mask = 32'h0000_0888;
    localparam csr_word_t mepc_write_mask = 32'hffff_fffc;

    // Interrupt bit positions shared by mie and mip
    localparam int irq_soft_bit = 3;
    localparam int irq_timer_bit = 7;
    localparam int irq_ext_bit = 11;

    localparam int mstatus_mie_bit = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lo = 11;
    localparam int mstatus_mpp_hi = 12;
    localparam logic [1:0] machine_mode = 2'b11;

    typedef struct packed {
        logic valid;
        csr_addr_t addr;
        csr_word_t data;
    } csr_write_t;

endpackage
